/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int xlen = 32;

	// register 0 reads as zero
	typedef logic [4:0] reg_addr_t;

	// instruction bits 31:26
	// rt 25:21, ra 20:16, rb 15:11, imm16 15:0, jump target 25:0
	typedef enum logic [5:0] {
		op_nop  = 6'h00,
		op_add  = 6'h01,
		op_sub  = 6'h02,
		op_and  = 6'h03,
		op_or   = 6'h04,
		op_xor  = 6'h05,
		op_addi = 6'h08,
		op_lw   = 6'h10,
		op_sw   = 6'h11,
		op_beq  = 6'h18,
		op_j    = 6'h1c
	} opcode_t;

	// execute to memory
	typedef struct packed {
		// alu result, or the address for lw and sw
		logic [xlen-1:0] result;
		logic [xlen-1:0] store_data;
		reg_addr_t       rd;
		logic            wr_en;
		logic            is_load;
		logic            is_store;
	} decoded_t;

	// memory back to execute
	typedef struct packed {
		logic            valid;
		reg_addr_t       rd;
		logic [xlen-1:0] data;
	} wb_t;

	// bubble
	localparam logic [31:0] nop_word = 32'h0000_0000;

endpackage

`default_nettype wire

/* logic/mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

// processor side of a cache, request held while strobe is high
interface mem_if;

	logic                     strobe;
	// 1 for read
	logic                     rw;
	logic [cpu_pkg::xlen-1:0] address;
	logic [cpu_pkg::xlen-1:0] wdata;
	logic [cpu_pkg::xlen-1:0] rdata;
	logic                     ready;

	modport requester (
		output strobe, rw, address, wdata,
		input  rdata, ready
	);

	modport responder (
		input  strobe, rw, address, wdata,
		output rdata, ready
	);

endinterface

`default_nettype wire

/* logic/direct_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module direct_cache #(
	parameter int cache_lines = 16
) (
	input  logic                     clock,
	input  logic                     rst_n,
	mem_if.responder                 proc,
	output logic                     sys_strobe,
	output logic                     sys_rw,
	output logic [cpu_pkg::xlen-1:0] sys_address,
	output logic [cpu_pkg::xlen-1:0] sys_wdata,
	input  logic [cpu_pkg::xlen-1:0] sys_rdata,
	input  logic                     sys_ready
);

	localparam int idx_w = $clog2(cache_lines);
	localparam int tag_w = cpu_pkg::xlen - idx_w - 2;

	typedef enum logic [1:0] {s_idle, s_fill, s_write, s_done} state_t;

	state_t                   state;
	logic [cache_lines-1:0]   valid_mem;
	logic [tag_w-1:0]         tag_mem [cache_lines];
	logic [cpu_pkg::xlen-1:0] data_mem [cache_lines];
	logic [idx_w-1:0]         idx;
	logic [tag_w-1:0]         tag;
	logic                     hit;

	// word addressed lines
	assign idx = proc.address[idx_w+1:2];
	assign tag = proc.address[cpu_pkg::xlen-1:idx_w+2];
	assign hit = valid_mem[idx] && (tag_mem[idx] == tag);

	assign proc.rdata = data_mem[idx];

	always_comb begin
		case (state)
			s_idle:  proc.ready = !proc.strobe || (proc.rw && hit);
			// write-through finished, one cycle to complete it
			s_done:  proc.ready = 1'b1;
			default: proc.ready = 1'b0;
		endcase
	end

	// request comes straight from the held processor side
	assign sys_strobe  = (state == s_fill) || (state == s_write);
	assign sys_rw      = (state == s_fill);
	assign sys_address = proc.address;
	assign sys_wdata   = proc.wdata;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= s_idle;
			valid_mem <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (proc.strobe && !proc.rw) begin
						state <= s_write;
					end else if (proc.strobe && !hit) begin
						state <= s_fill;
					end
				end
				s_fill: begin
					if (sys_ready) begin
						state          <= s_idle;
						valid_mem[idx] <= 1'b1;
					end
				end
				s_write: begin
					if (sys_ready) begin
						state <= s_done;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// no allocate on a write miss
	always_ff @(posedge clock) begin
		if (state == s_fill && sys_ready) begin
			tag_mem[idx]  <= tag;
			data_mem[idx] <= sys_rdata;
		end else if (state == s_write && sys_ready && hit) begin
			data_mem[idx] <= proc.wdata;
		end
	end

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     run,
	input  logic                     data_wait,
	mem_if.requester                 imem,
	input  logic                     redirect,
	input  logic [cpu_pkg::xlen-1:0] redirect_pc,
	output logic                     advance,
	output logic [31:0]              instr
);

	logic [cpu_pkg::xlen-1:0] pc;

	// read of the pc is always pending
	assign imem.strobe  = 1'b1;
	assign imem.rw      = 1'b1;
	assign imem.address = pc;
	assign imem.wdata   = '0;

	// whole pipeline moves together
	assign advance = run && imem.ready && !data_wait;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc    <= reset_pc;
			instr <= cpu_pkg::nop_word;
		end else if (advance) begin
			if (redirect) begin
				// squash the word fetched behind a taken branch
				instr <= cpu_pkg::nop_word;
				pc    <= redirect_pc;
			end else begin
				instr <= imem.rdata;
				pc    <= pc + 32'd4;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
	parameter logic [cpu_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     advance,
	input  logic [31:0]              instr,
	input  cpu_pkg::wb_t             wb,
	output logic                     redirect,
	output logic [cpu_pkg::xlen-1:0] redirect_pc,
	output cpu_pkg::decoded_t        ex_out,
	output logic                     alu_overflow
);

	cpu_pkg::opcode_t         opcode;
	cpu_pkg::reg_addr_t       rt;
	cpu_pkg::reg_addr_t       ra;
	cpu_pkg::reg_addr_t       rb;
	logic [cpu_pkg::xlen-1:0] regs [32];
	logic [cpu_pkg::xlen-1:0] imm_ext;
	logic [cpu_pkg::xlen-1:0] rt_val;
	logic [cpu_pkg::xlen-1:0] ra_val;
	logic [cpu_pkg::xlen-1:0] rb_val;
	logic [cpu_pkg::xlen-1:0] alu_b;
	logic [cpu_pkg::xlen-1:0] sum;
	logic [cpu_pkg::xlen-1:0] diff;
	logic [cpu_pkg::xlen-1:0] alu_result;
	logic [cpu_pkg::xlen-1:0] next_pc;
	logic                     uses_imm;
	logic                     overflow;
	logic                     writes_reg;
	logic                     is_load;
	logic                     is_store;

	assign opcode  = cpu_pkg::opcode_t'(instr[31:26]);
	assign rt      = instr[25:21];
	assign ra      = instr[20:16];
	assign rb      = instr[15:11];
	assign imm_ext = {{16{instr[15]}}, instr[15:0]};

	always_ff @(posedge clock) begin
		if (advance && wb.valid && wb.rd != 5'd0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// writeback of the memory stage bypasses the file
	assign rt_val = (rt == 5'd0) ? '0 : (wb.valid && wb.rd == rt) ? wb.data : regs[rt];
	assign ra_val = (ra == 5'd0) ? '0 : (wb.valid && wb.rd == ra) ? wb.data : regs[ra];
	assign rb_val = (rb == 5'd0) ? '0 : (wb.valid && wb.rd == rb) ? wb.data : regs[rb];

	assign uses_imm = opcode inside {cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw};
	assign alu_b    = uses_imm ? imm_ext : rb_val;
	assign sum      = ra_val + alu_b;
	assign diff     = ra_val - rb_val;

	always_comb begin
		alu_result = '0;
		overflow   = 1'b0;
		writes_reg = 1'b0;
		is_load    = 1'b0;
		is_store   = 1'b0;
		case (opcode)
			cpu_pkg::op_add, cpu_pkg::op_addi: begin
				alu_result = sum;
				writes_reg = 1'b1;
				overflow   = (ra_val[31] == alu_b[31]) && (sum[31] != ra_val[31]);
			end
			cpu_pkg::op_sub: begin
				alu_result = diff;
				writes_reg = 1'b1;
				overflow   = (ra_val[31] != rb_val[31]) && (diff[31] != ra_val[31]);
			end
			cpu_pkg::op_and: begin
				alu_result = ra_val & rb_val;
				writes_reg = 1'b1;
			end
			cpu_pkg::op_or: begin
				alu_result = ra_val | rb_val;
				writes_reg = 1'b1;
			end
			cpu_pkg::op_xor: begin
				alu_result = ra_val ^ rb_val;
				writes_reg = 1'b1;
			end
			cpu_pkg::op_lw: begin
				alu_result = sum;
				writes_reg = 1'b1;
				is_load    = 1'b1;
			end
			cpu_pkg::op_sw: begin
				alu_result = sum;
				is_store   = 1'b1;
			end
			default: ;
		endcase
	end

	// beq offset counts words from the following instruction
	assign redirect    = (opcode == cpu_pkg::op_j) ||
	                     (opcode == cpu_pkg::op_beq && rt_val == ra_val);
	assign redirect_pc = (opcode == cpu_pkg::op_j) ? {4'b0000, instr[25:0], 2'b00} :
	                     next_pc + {imm_ext[29:0], 2'b00};

	// mirrors the fetch pc, one word past this instruction
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			next_pc <= reset_pc;
		end else if (advance) begin
			next_pc <= redirect ? redirect_pc : next_pc + 32'd4;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ex_out       <= '0;
			alu_overflow <= 1'b0;
		end else if (advance) begin
			ex_out.result     <= alu_result;
			ex_out.store_data <= rt_val;
			ex_out.rd         <= rt;
			ex_out.wr_en      <= writes_reg;
			ex_out.is_load    <= is_load;
			ex_out.is_store   <= is_store;
			// sticky until reset
			if (overflow) begin
				alu_overflow <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              advance,
	input  cpu_pkg::decoded_t ex_in,
	mem_if.requester          dmem,
	output cpu_pkg::wb_t      wb,
	output logic              data_wait
);

	logic store_done;

	// a finished store must not go out again while the pipe is held
	assign dmem.strobe  = ex_in.is_load || (ex_in.is_store && !store_done);
	assign dmem.rw      = ex_in.is_load;
	assign dmem.address = ex_in.result;
	assign dmem.wdata   = ex_in.store_data;

	assign data_wait = dmem.strobe && !dmem.ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			store_done <= 1'b0;
		end else if (advance) begin
			store_done <= 1'b0;
		end else if (ex_in.is_store && dmem.strobe && dmem.ready) begin
			store_done <= 1'b1;
		end
	end

	// load data or alu result
	assign wb.valid = ex_in.wr_en;
	assign wb.rd    = ex_in.rd;
	assign wb.data  = ex_in.is_load ? dmem.rdata : ex_in.result;

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int                       cache_lines = 16,
	parameter logic [cpu_pkg::xlen-1:0] reset_pc    = '0
) (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     run,
	output logic                     alu_overflow,

	output logic                     im_enable,
	output logic                     im_read,
	output logic                     im_write,
	output logic [cpu_pkg::xlen-1:0] im_address,
	input  logic [cpu_pkg::xlen-1:0] im_rdata,
	input  logic                     im_ready,

	output logic                     dm_enable,
	output logic                     dm_read,
	output logic                     dm_write,
	output logic [cpu_pkg::xlen-1:0] dm_address,
	output logic [cpu_pkg::xlen-1:0] dm_wdata,
	input  logic [cpu_pkg::xlen-1:0] dm_rdata,
	input  logic                     dm_ready
);

	mem_if imem_bus ();
	mem_if dmem_bus ();

	logic                     advance;
	logic                     data_wait;
	logic                     redirect;
	logic [cpu_pkg::xlen-1:0] redirect_pc;
	logic [31:0]              instr;
	cpu_pkg::decoded_t        ex_data;
	cpu_pkg::wb_t             wb_data;
	logic                     i_sys_rw;
	logic                     d_sys_rw;

	assign im_read  = i_sys_rw;
	assign im_write = !i_sys_rw;
	assign dm_read  = d_sys_rw;
	assign dm_write = !d_sys_rw;

	fetch_stage #(.reset_pc(reset_pc)) fetch0 (
		.clock(clock),
		.rst_n(rst_n),
		.run(run),
		.data_wait(data_wait),
		.imem(imem_bus.requester),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.advance(advance),
		.instr(instr)
	);

	execute_stage #(.reset_pc(reset_pc)) execute0 (
		.clock(clock),
		.rst_n(rst_n),
		.advance(advance),
		.instr(instr),
		.wb(wb_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_out(ex_data),
		.alu_overflow(alu_overflow)
	);

	mem_stage mem0 (
		.clock(clock),
		.rst_n(rst_n),
		.advance(advance),
		.ex_in(ex_data),
		.dmem(dmem_bus.requester),
		.wb(wb_data),
		.data_wait(data_wait)
	);

	// instruction side never writes
	direct_cache #(.cache_lines(cache_lines)) icache0 (
		.clock(clock),
		.rst_n(rst_n),
		.proc(imem_bus.responder),
		.sys_strobe(im_enable),
		.sys_rw(i_sys_rw),
		.sys_address(im_address),
		.sys_wdata(),
		.sys_rdata(im_rdata),
		.sys_ready(im_ready)
	);

	direct_cache #(.cache_lines(cache_lines)) dcache0 (
		.clock(clock),
		.rst_n(rst_n),
		.proc(dmem_bus.responder),
		.sys_strobe(dm_enable),
		.sys_rw(d_sys_rw),
		.sys_address(dm_address),
		.sys_wdata(dm_wdata),
		.sys_rdata(dm_rdata),
		.sys_ready(dm_ready)
	);

endmodule

`default_nettype wire

/* testbench/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input logic                     clock,
	input logic                     rst_n,
	input logic                     strobe,
	input logic                     rw,
	input logic                     hit,
	input logic                     ready,
	input logic                     sys_strobe,
	input logic                     sys_rw,
	input logic [cpu_pkg::xlen-1:0] sys_address,
	input logic [cpu_pkg::xlen-1:0] sys_wdata,
	input logic                     sys_ready
);

	int violations = 0;

	// memory side request frozen until the memory answers
	request_held: assert property (@(posedge clock) disable iff (!rst_n)
		sys_strobe && !sys_ready |=> sys_strobe && $stable(sys_rw) &&
			$stable(sys_address) && $stable(sys_wdata))
	else begin
		violations++;
		$error("system request changed before sys_ready");
	end

	hit_ready: assert property (@(posedge clock) disable iff (!rst_n)
		strobe && rw && hit && !sys_strobe |-> ready)
	else begin
		violations++;
		$error("read hit without ready");
	end

	miss_not_ready: assert property (@(posedge clock) disable iff (!rst_n)
		sys_strobe |-> !ready)
	else begin
		violations++;
		$error("sys_strobe high while ready is high");
	end

endmodule

bind direct_cache cpu_properties props0 (
	.clock(clock),
	.rst_n(rst_n),
	.strobe(proc.strobe),
	.rw(proc.rw),
	.hit(hit),
	.ready(proc.ready),
	.sys_strobe(sys_strobe),
	.sys_rw(sys_rw),
	.sys_address(sys_address),
	.sys_wdata(sys_wdata),
	.sys_ready(sys_ready)
);

`default_nettype wire

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	typedef struct packed {
		logic [cpu_pkg::xlen-1:0] address;
		logic [cpu_pkg::xlen-1:0] data;
	} store_t;

	logic                     clock;
	logic                     rst_n;
	logic                     run;
	logic                     alu_overflow;
	logic                     im_enable;
	logic                     im_read;
	logic                     im_write;
	logic [cpu_pkg::xlen-1:0] im_address;
	logic [cpu_pkg::xlen-1:0] im_rdata;
	logic                     im_ready;
	logic                     dm_enable;
	logic                     dm_read;
	logic                     dm_write;
	logic [cpu_pkg::xlen-1:0] dm_address;
	logic [cpu_pkg::xlen-1:0] dm_wdata;
	logic [cpu_pkg::xlen-1:0] dm_rdata;
	logic                     dm_ready;

	logic [31:0] imem [64];
	logic [31:0] dmem [64];
	int          im_reads [64];
	store_t      wr_log [$];
	int          prog_len;
	logic        im_busy;
	logic        dm_busy;
	logic [1:0]  im_count;
	logic [1:0]  dm_count;
	logic [15:0] i_lfsr = 16'd88;
	logic [15:0] d_lfsr = 16'd88;

	cpu_top #(.cache_lines(16), .reset_pc(32'h0)) dut0 (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
	endfunction

	// instruction memory with a random 0 to 3 cycle delay
	always @(posedge clock) begin
		if (!rst_n) begin
			im_ready <= 1'b0;
			im_busy  <= 1'b0;
		end else begin
			im_ready <= 1'b0;
			if (!im_enable || im_ready) begin
				im_busy <= 1'b0;
			end else if (!im_busy) begin
				im_busy <= 1'b1;
				i_lfsr = lfsr_step(i_lfsr);
				im_count[0] <= i_lfsr[0];
				i_lfsr = lfsr_step(i_lfsr);
				im_count[1] <= i_lfsr[0];
			end else if (im_count == 2'd0) begin
				check_flag("im_read", im_read, 1'b1);
				check_flag("im_write", im_write, 1'b0);
				im_ready <= 1'b1;
				im_rdata <= imem[im_address[7:2]];
				im_reads[im_address[7:2]] <= im_reads[im_address[7:2]] + 1;
			end else begin
				im_count <= im_count - 2'd1;
			end
		end
	end

	// data memory that logs every write
	always @(posedge clock) begin
		if (!rst_n) begin
			dm_ready <= 1'b0;
			dm_busy  <= 1'b0;
		end else begin
			dm_ready <= 1'b0;
			if (!dm_enable || dm_ready) begin
				dm_busy <= 1'b0;
			end else if (!dm_busy) begin
				dm_busy <= 1'b1;
				d_lfsr = lfsr_step(d_lfsr);
				dm_count[0] <= d_lfsr[0];
				d_lfsr = lfsr_step(d_lfsr);
				dm_count[1] <= d_lfsr[0];
			end else if (dm_count == 2'd0) begin
				if (dm_read === dm_write) begin
					report_failure("dm_read and dm_write are equal during a data request");
				end
				dm_ready <= 1'b1;
				if (dm_write) begin
					dmem[dm_address[7:2]] <= dm_wdata;
					wr_log.push_back(store_t'{dm_address, dm_wdata});
				end else begin
					dm_rdata <= dmem[dm_address[7:2]];
				end
			end else begin
				dm_count <= dm_count - 2'd1;
			end
		end
	end

	always @(negedge clock) begin
		check_assertions();
	end

	function automatic logic [31:0] enc_reg(cpu_pkg::opcode_t op, int rt, int ra, int rb);
		return {op, rt[4:0], ra[4:0], rb[4:0], 11'd0};
	endfunction

	function automatic logic [31:0] enc_imm(cpu_pkg::opcode_t op, int rt, int ra, int imm);
		return {op, rt[4:0], ra[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_jump(int word);
		return {cpu_pkg::op_j, word[25:0]};
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [cpu_pkg::xlen-1:0] got,
			input logic [cpu_pkg::xlen-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_store(input int index, input store_t exp);
		store_t got;
		if (index >= wr_log.size()) begin
			report_failure($sformatf("data write %0d never happened", index));
		end
		got = wr_log[index];
		if (got !== exp) begin
			report_failure($sformatf("CHECK FAILED store[%0d] got %h/%h expected %h/%h",
				index, got.address, got.data, exp.address, exp.data));
		end
	endtask

	task automatic check_assertions();
		if (dut0.icache0.props0.violations != 0 || dut0.dcache0.props0.violations != 0) begin
			report_failure("a cache handshake assertion failed");
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// hold reset and clear both memories and the logs
	task automatic start_test();
		@(posedge clock);
		rst_n <= 1'b0;
		run   <= 1'b0;
		@(negedge clock);
		prog_len = 0;
		wr_log.delete();
		for (int i = 0; i < 64; i++) begin
			imem[i]     = cpu_pkg::nop_word;
			dmem[i]     = 32'hda7a_0000 ^ (i << 2);
			im_reads[i] = 0;
		end
	endtask

	task automatic release_reset(input logic start);
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		run   <= start;
	endtask

	task automatic wait_writes(input int count);
		int cycles;
		cycles = 0;
		while (wr_log.size() < count) begin
			@(negedge clock);
			cycles++;
			if (cycles > 2000) begin
				report_failure($sformatf("timed out waiting for %0d data writes, saw %0d",
					count, wr_log.size()));
			end
		end
	endtask

	task automatic expect_quiet(input int count, input int window);
		for (int i = 0; i < window; i++) begin
			@(negedge clock);
			if (wr_log.size() != count) begin
				report_failure($sformatf("saw %0d data writes where %0d were expected",
					wr_log.size(), count));
			end
		end
	endtask

	task automatic finish_program(input int count);
		wait_writes(count);
		expect_quiet(count, 40);
	endtask

	task automatic test_forwarding();
		logic [31:0] v [8];
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 'h1234));
		emit(enc_imm(cpu_pkg::op_addi, 2, 1, -5));
		emit(enc_reg(cpu_pkg::op_add, 3, 2, 1));
		emit(enc_reg(cpu_pkg::op_sub, 4, 3, 1));
		emit(enc_reg(cpu_pkg::op_xor, 5, 4, 3));
		emit(enc_reg(cpu_pkg::op_or, 6, 5, 1));
		emit(enc_reg(cpu_pkg::op_and, 7, 6, 5));
		for (int k = 2; k <= 7; k++) begin
			emit(enc_imm(cpu_pkg::op_sw, k, 0, 'h80 + 4 * (k - 2)));
		end
		emit(enc_jump(prog_len));
		v[1] = 32'h1234;
		v[2] = v[1] - 32'd5;
		v[3] = v[2] + v[1];
		v[4] = v[3] - v[1];
		v[5] = v[4] ^ v[3];
		v[6] = v[5] | v[1];
		v[7] = v[6] & v[5];
		release_reset(1'b1);
		finish_program(6);
		for (int k = 2; k <= 7; k++) begin
			check_store(k - 2, store_t'{32'h80 + 4 * (k - 2), v[k]});
		end
	endtask

	task automatic test_load_use();
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 'h555));
		emit(enc_imm(cpu_pkg::op_addi, 4, 0, 'h100));
		emit(enc_imm(cpu_pkg::op_sw, 1, 0, 'h20));
		emit(enc_imm(cpu_pkg::op_lw, 2, 0, 'h20));
		emit(enc_reg(cpu_pkg::op_add, 3, 2, 4));
		emit(enc_imm(cpu_pkg::op_sw, 3, 0, 'h24));
		emit(enc_jump(prog_len));
		release_reset(1'b1);
		finish_program(2);
		check_store(0, store_t'{32'h20, 32'h555});
		check_store(1, store_t'{32'h24, 32'h555 + 32'h100});
	endtask

	task automatic test_branches();
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 1));
		emit(enc_imm(cpu_pkg::op_addi, 2, 0, 2));
		emit(enc_imm(cpu_pkg::op_beq, 1, 2, 2));
		emit(enc_imm(cpu_pkg::op_sw, 1, 0, 'h30));
		emit(enc_imm(cpu_pkg::op_addi, 3, 0, 1));
		// taken and lands on word 8
		emit(enc_imm(cpu_pkg::op_beq, 1, 3, 2));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h34));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h38));
		emit(enc_imm(cpu_pkg::op_sw, 3, 0, 'h3c));
		emit(enc_jump(11));
		emit(enc_imm(cpu_pkg::op_sw, 1, 0, 'h40));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h44));
		emit(enc_jump(prog_len));
		release_reset(1'b1);
		finish_program(3);
		check_store(0, store_t'{32'h30, 32'd1});
		check_store(1, store_t'{32'h3c, 32'd1});
		check_store(2, store_t'{32'h44, 32'd2});
	endtask

	task automatic test_overflow();
		start_test();
		dmem[20] = 32'h7fff_ffff;
		emit(enc_imm(cpu_pkg::op_lw, 1, 0, 'h50));
		emit(enc_imm(cpu_pkg::op_addi, 2, 0, 1));
		emit(enc_reg(cpu_pkg::op_add, 3, 1, 2));
		emit(enc_imm(cpu_pkg::op_addi, 4, 0, 7));
		emit(enc_imm(cpu_pkg::op_sw, 3, 0, 'h54));
		emit(enc_imm(cpu_pkg::op_sw, 4, 0, 'h58));
		emit(enc_jump(prog_len));
		release_reset(1'b1);
		finish_program(2);
		check_store(0, store_t'{32'h54, 32'h7fff_ffff + 32'h1});
		check_store(1, store_t'{32'h58, 32'd7});
		check_flag("alu_overflow", alu_overflow, 1'b1);
		// no overflow in this one
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 5));
		emit(enc_imm(cpu_pkg::op_addi, 2, 1, -7));
		emit(enc_reg(cpu_pkg::op_sub, 3, 2, 1));
		emit(enc_imm(cpu_pkg::op_sw, 3, 0, 'h60));
		emit(enc_jump(prog_len));
		release_reset(1'b1);
		@(negedge clock);
		check_flag("alu_overflow", alu_overflow, 1'b0);
		finish_program(1);
		check_store(0, store_t'{32'h60, 32'd5 - 32'd7 - 32'd5});
		check_flag("alu_overflow", alu_overflow, 1'b0);
	endtask

	task automatic test_loop_fetch();
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 3));
		emit(enc_imm(cpu_pkg::op_addi, 2, 0, 0));
		emit(enc_imm(cpu_pkg::op_addi, 2, 2, 5));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h70));
		emit(enc_imm(cpu_pkg::op_addi, 1, 1, -1));
		emit(enc_imm(cpu_pkg::op_beq, 1, 0, 1));
		emit(enc_jump(2));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h78));
		emit(enc_jump(prog_len));
		release_reset(1'b1);
		finish_program(4);
		for (int k = 0; k < 3; k++) begin
			check_store(k, store_t'{32'h70, 32'd5 * (k + 1)});
		end
		check_store(3, store_t'{32'h78, 32'd15});
		// the word after the last jump is prefetched once too
		for (int i = 0; i < 64; i++) begin
			check_word($sformatf("im_reads[%0d]", i), im_reads[i],
				(i <= prog_len) ? 32'd1 : 32'd0);
		end
	endtask

	task automatic test_run_hold();
		start_test();
		emit(enc_imm(cpu_pkg::op_addi, 1, 0, 'h11));
		emit(enc_imm(cpu_pkg::op_sw, 1, 0, 'h0));
		emit(enc_imm(cpu_pkg::op_addi, 2, 1, 'h22));
		emit(enc_imm(cpu_pkg::op_sw, 2, 0, 'h4));
		emit(enc_jump(prog_len));
		release_reset(1'b0);
		expect_quiet(0, 50);
		@(posedge clock);
		run <= 1'b1;
		finish_program(2);
		check_store(0, store_t'{32'h0, 32'h11});
		check_store(1, store_t'{32'h4, 32'h11 + 32'h22});
	endtask

	initial begin
		rst_n    = 1'b0;
		run      = 1'b0;
		im_rdata = '0;
		im_ready = 1'b0;
		dm_rdata = '0;
		dm_ready = 1'b0;
		prog_len = 0;
		test_forwarding();
		test_load_use();
		test_branches();
		test_overflow();
		test_loop_fetch();
		test_run_hold();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
logic/cpu_pkg.sv
logic/mem_if.sv
logic/direct_cache.sv
logic/fetch_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/cpu_top.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv
